// ==== hdl/icb_pkg.sv ====
// icb peripheral fabric
// shared address map, widths and slave sizing

package icb_pkg;

	// bus widths
	localparam int ICB_AW = 32;
	localparam int ICB_DW = 32;
	localparam int ICB_MW = ICB_DW / 8; // one mask bit per byte

	localparam int SLV_NUM = 5;

	// address windows indexed by slave number
	localparam logic [ICB_AW-1:0] SLV_BASE [SLV_NUM] = '{
		32'h1000_0000,
		32'hF000_0000,
		32'hF400_0000,
		32'h4000_0000,
		32'h6000_0000
	};

	localparam logic [ICB_AW-1:0] SLV_RANGE [SLV_NUM] = '{
		32'h0000_4000, // 16 KiB
		32'h0040_0000, // 4 MiB
		32'h0400_0000, // 64 MiB
		32'h0001_0000, // 64 KiB
		32'h0080_0000  // 8 MiB
	};

	// slave storage and latency
	localparam int SLV_MEM_WORDS = 64;
	localparam int SLV_ADDR_W = $clog2(SLV_MEM_WORDS) + 2; // byte offset bits
	localparam int SLV_WAIT_BASE = 1;
	localparam int SLV_WAIT_W = $clog2(SLV_WAIT_BASE + SLV_NUM);

	// outstanding command limit in the distributor
	localparam int RT_FIFO_DEPTH = 4;

	typedef enum logic [1:0] {
		SLV_IDLE,
		SLV_WAIT,
		SLV_RSP
	} slv_state_e;

endpackage

// ==== hdl/fifo_based_on_regs.sv ====
// register based fwft fifo

`timescale 1ns/100ps

module fifo_based_on_regs #(
	parameter int fifo_depth = 4,
	parameter int fifo_data_width = 8
) (
	input  logic                       clk,
	input  logic                       rst_n,

	input  logic                       fifo_wen,
	input  logic [fifo_data_width-1:0] fifo_din,
	output logic                       fifo_full_n,

	input  logic                       fifo_ren,
	output logic [fifo_data_width-1:0] fifo_dout,
	output logic                       fifo_empty_n
);

	logic [fifo_data_width-1:0] regs [fifo_depth];
	logic [$clog2(fifo_depth)-1:0] wptr;
	logic [$clog2(fifo_depth)-1:0] rptr;
	logic [$clog2(fifo_depth+1)-1:0] cnt;
	logic [$clog2(fifo_depth+1)-1:0] cnt_nxt;
	logic wr;
	logic rd;

	assign wr = fifo_wen & fifo_full_n; // writes while full are ignored
	assign rd = fifo_ren & fifo_empty_n;

	// head word always on the output
	assign fifo_dout = regs[rptr];

	always_comb begin
		unique case ({wr, rd})
			2'b10:   cnt_nxt = cnt + 1'b1;
			2'b01:   cnt_nxt = cnt - 1'b1;
			default: cnt_nxt = cnt;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
			cnt <= '0;
			fifo_full_n <= 1'b1;
			fifo_empty_n <= 1'b0;
		end else begin
			if (wr)
				wptr <= (wptr == fifo_depth - 1) ? '0 : wptr + 1'b1;
			if (rd)
				rptr <= (rptr == fifo_depth - 1) ? '0 : rptr + 1'b1;
			cnt <= cnt_nxt;
			// flags follow the next count
			fifo_full_n <= (cnt_nxt != fifo_depth);
			fifo_empty_n <= (cnt_nxt != 0);
		end
	end

	always_ff @(posedge clk) begin
		if (wr)
			regs[wptr] <= fifo_din;
	end

endmodule

// ==== hdl/icb_mem_slave.sv ====
// icb register memory slave

`timescale 1ns/100ps

module icb_mem_slave #(
	parameter int slv_idx = 0
) (
	input  logic                       clk,
	input  logic                       rst_n,

	input  logic [icb_pkg::ICB_AW-1:0] cmd_addr,
	input  logic                       cmd_read,
	input  logic [icb_pkg::ICB_DW-1:0] cmd_wdata,
	input  logic [icb_pkg::ICB_MW-1:0] cmd_wmask,
	input  logic                       cmd_valid,
	output logic                       cmd_ready,

	output logic [icb_pkg::ICB_DW-1:0] rsp_rdata,
	output logic                       rsp_err,
	output logic                       rsp_valid,
	input  logic                       rsp_ready
);

	icb_pkg::slv_state_e state;
	logic [icb_pkg::SLV_WAIT_W-1:0] wait_cnt;
	logic [icb_pkg::ICB_DW-1:0] mem [icb_pkg::SLV_MEM_WORDS];
	logic [icb_pkg::ICB_AW-1:0] offset;
	logic [icb_pkg::SLV_ADDR_W-3:0] word_idx;
	logic in_range;
	logic cmd_acc;

	assign offset = cmd_addr - icb_pkg::SLV_BASE[slv_idx];
	assign word_idx = offset[icb_pkg::SLV_ADDR_W-1:2];
	assign in_range = (offset[icb_pkg::ICB_AW-1:icb_pkg::SLV_ADDR_W] == '0);

	assign cmd_ready = (state == icb_pkg::SLV_IDLE);
	assign cmd_acc = cmd_valid & cmd_ready;
	assign rsp_valid = (state == icb_pkg::SLV_RSP);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= icb_pkg::SLV_IDLE;
			wait_cnt <= '0;
		end else begin
			unique case (state)
				icb_pkg::SLV_IDLE: if (cmd_acc) begin
					state <= icb_pkg::SLV_WAIT;
					wait_cnt <= '0;
				end
				icb_pkg::SLV_WAIT: begin
					// latency grows with the slave index
					if (wait_cnt == icb_pkg::SLV_WAIT_BASE + slv_idx - 1)
						state <= icb_pkg::SLV_RSP;
					else
						wait_cnt <= wait_cnt + 1'b1;
				end
				icb_pkg::SLV_RSP: if (rsp_ready)
					state <= icb_pkg::SLV_IDLE;
				default: state <= icb_pkg::SLV_IDLE;
			endcase
		end
	end

	// storage and response payload
	always_ff @(posedge clk) begin
		if (cmd_acc) begin
			rsp_err <= ~in_range;
			rsp_rdata <= (cmd_read && in_range) ? mem[word_idx] : '0;
			if (!cmd_read && in_range) begin
				for (int b = 0; b < icb_pkg::ICB_MW; b++) begin
					if (cmd_wmask[b])
						mem[word_idx][b*8 +: 8] <= cmd_wdata[b*8 +: 8]; // byte merge
				end
			end
		end
	end

endmodule

// ==== hdl/icb_1s_to_5m.sv ====
// icb one-to-five address distributor
// in-order response return through a route fifo

`timescale 1ns/100ps

module icb_1s_to_5m (
	input  logic clk,
	input  logic rst_n,

	// boundary port
	input  logic [icb_pkg::ICB_AW-1:0] s_icb_cmd_addr,
	input  logic                       s_icb_cmd_read,
	input  logic [icb_pkg::ICB_DW-1:0] s_icb_cmd_wdata,
	input  logic [icb_pkg::ICB_MW-1:0] s_icb_cmd_wmask,
	input  logic                       s_icb_cmd_valid,
	output logic                       s_icb_cmd_ready,
	output logic [icb_pkg::ICB_DW-1:0] s_icb_rsp_rdata,
	output logic                       s_icb_rsp_err,
	output logic                       s_icb_rsp_valid,
	input  logic                       s_icb_rsp_ready,

	// slave side, one entry per slave
	output logic [icb_pkg::SLV_NUM-1:0][icb_pkg::ICB_AW-1:0] m_icb_cmd_addr,
	output logic [icb_pkg::SLV_NUM-1:0]                      m_icb_cmd_read,
	output logic [icb_pkg::SLV_NUM-1:0][icb_pkg::ICB_DW-1:0] m_icb_cmd_wdata,
	output logic [icb_pkg::SLV_NUM-1:0][icb_pkg::ICB_MW-1:0] m_icb_cmd_wmask,
	output logic [icb_pkg::SLV_NUM-1:0]                      m_icb_cmd_valid,
	input  logic [icb_pkg::SLV_NUM-1:0]                      m_icb_cmd_ready,
	input  logic [icb_pkg::SLV_NUM-1:0][icb_pkg::ICB_DW-1:0] m_icb_rsp_rdata,
	input  logic [icb_pkg::SLV_NUM-1:0]                      m_icb_rsp_err,
	input  logic [icb_pkg::SLV_NUM-1:0]                      m_icb_rsp_valid,
	output logic [icb_pkg::SLV_NUM-1:0]                      m_icb_rsp_ready
);

	logic [icb_pkg::SLV_NUM-1:0] slv_sel;  // one-hot window hit
	logic [icb_pkg::SLV_NUM-1:0] head_sel; // slave owed the next response
	logic rt_wen;
	logic rt_ren;
	logic rt_full_n;
	logic rt_empty_n;
	logic head_valid;

	// an address outside every window never gets ready
	always_comb begin
		for (int k = 0; k < icb_pkg::SLV_NUM; k++) begin
			slv_sel[k] = (s_icb_cmd_addr >= icb_pkg::SLV_BASE[k]) &&
				(s_icb_cmd_addr < icb_pkg::SLV_BASE[k] + icb_pkg::SLV_RANGE[k]);
		end
	end

	// command fan-out
	always_comb begin
		for (int k = 0; k < icb_pkg::SLV_NUM; k++) begin
			m_icb_cmd_addr[k] = s_icb_cmd_addr;
			m_icb_cmd_read[k] = s_icb_cmd_read;
			m_icb_cmd_wdata[k] = s_icb_cmd_wdata;
			m_icb_cmd_wmask[k] = s_icb_cmd_wmask;
			m_icb_cmd_valid[k] = s_icb_cmd_valid & slv_sel[k] & rt_full_n;
		end
	end

	assign s_icb_cmd_ready = rt_full_n & (|(slv_sel & m_icb_cmd_ready));
	assign rt_wen = s_icb_cmd_valid & s_icb_cmd_ready;

	fifo_based_on_regs #(
		.fifo_depth(icb_pkg::RT_FIFO_DEPTH),
		.fifo_data_width(icb_pkg::SLV_NUM)
	) i_rt_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.fifo_wen(rt_wen),
		.fifo_din(slv_sel),
		.fifo_full_n(rt_full_n),
		.fifo_ren(rt_ren),
		.fifo_dout(head_sel),
		.fifo_empty_n(rt_empty_n)
	);

	// response mux on the fifo head
	always_comb begin
		s_icb_rsp_rdata = '0;
		s_icb_rsp_err = 1'b0;
		head_valid = 1'b0;
		for (int k = 0; k < icb_pkg::SLV_NUM; k++) begin
			if (head_sel[k]) begin
				s_icb_rsp_rdata = s_icb_rsp_rdata | m_icb_rsp_rdata[k];
				s_icb_rsp_err = s_icb_rsp_err | m_icb_rsp_err[k];
				head_valid = head_valid | m_icb_rsp_valid[k];
			end
		end
	end

	assign s_icb_rsp_valid = rt_empty_n & head_valid; // stale head ignored when empty

	// ready goes to the head slave alone
	always_comb begin
		for (int k = 0; k < icb_pkg::SLV_NUM; k++) begin
			m_icb_rsp_ready[k] = rt_empty_n & head_sel[k] & s_icb_rsp_ready;
		end
	end

	assign rt_ren = s_icb_rsp_valid & s_icb_rsp_ready;

endmodule

// ==== hdl/icb_subsys_top.sv ====
// icb peripheral subsystem top

`timescale 1ns/100ps

module icb_subsys_top (
	input  logic                       clk,
	input  logic                       rst_n,

	input  logic [icb_pkg::ICB_AW-1:0] s_icb_cmd_addr,
	input  logic                       s_icb_cmd_read,
	input  logic [icb_pkg::ICB_DW-1:0] s_icb_cmd_wdata,
	input  logic [icb_pkg::ICB_MW-1:0] s_icb_cmd_wmask,
	input  logic                       s_icb_cmd_valid,
	output logic                       s_icb_cmd_ready,

	output logic [icb_pkg::ICB_DW-1:0] s_icb_rsp_rdata,
	output logic                       s_icb_rsp_err,
	output logic                       s_icb_rsp_valid,
	input  logic                       s_icb_rsp_ready
);

	// distributor to slave array
	logic [icb_pkg::SLV_NUM-1:0][icb_pkg::ICB_AW-1:0] m_icb_cmd_addr;
	logic [icb_pkg::SLV_NUM-1:0]                      m_icb_cmd_read;
	logic [icb_pkg::SLV_NUM-1:0][icb_pkg::ICB_DW-1:0] m_icb_cmd_wdata;
	logic [icb_pkg::SLV_NUM-1:0][icb_pkg::ICB_MW-1:0] m_icb_cmd_wmask;
	logic [icb_pkg::SLV_NUM-1:0]                      m_icb_cmd_valid;
	logic [icb_pkg::SLV_NUM-1:0]                      m_icb_cmd_ready;
	logic [icb_pkg::SLV_NUM-1:0][icb_pkg::ICB_DW-1:0] m_icb_rsp_rdata;
	logic [icb_pkg::SLV_NUM-1:0]                      m_icb_rsp_err;
	logic [icb_pkg::SLV_NUM-1:0]                      m_icb_rsp_valid;
	logic [icb_pkg::SLV_NUM-1:0]                      m_icb_rsp_ready;

	icb_1s_to_5m i_icb_1s_to_5m (
		.clk(clk),
		.rst_n(rst_n),
		.s_icb_cmd_addr(s_icb_cmd_addr),
		.s_icb_cmd_read(s_icb_cmd_read),
		.s_icb_cmd_wdata(s_icb_cmd_wdata),
		.s_icb_cmd_wmask(s_icb_cmd_wmask),
		.s_icb_cmd_valid(s_icb_cmd_valid),
		.s_icb_cmd_ready(s_icb_cmd_ready),
		.s_icb_rsp_rdata(s_icb_rsp_rdata),
		.s_icb_rsp_err(s_icb_rsp_err),
		.s_icb_rsp_valid(s_icb_rsp_valid),
		.s_icb_rsp_ready(s_icb_rsp_ready),
		.m_icb_cmd_addr(m_icb_cmd_addr),
		.m_icb_cmd_read(m_icb_cmd_read),
		.m_icb_cmd_wdata(m_icb_cmd_wdata),
		.m_icb_cmd_wmask(m_icb_cmd_wmask),
		.m_icb_cmd_valid(m_icb_cmd_valid),
		.m_icb_cmd_ready(m_icb_cmd_ready),
		.m_icb_rsp_rdata(m_icb_rsp_rdata),
		.m_icb_rsp_err(m_icb_rsp_err),
		.m_icb_rsp_valid(m_icb_rsp_valid),
		.m_icb_rsp_ready(m_icb_rsp_ready)
	);

	// slave k answers k cycles later than slave 0
	for (genvar k = 0; k < icb_pkg::SLV_NUM; k++) begin : g_slv
		icb_mem_slave #(
			.slv_idx(k)
		) i_icb_mem_slave (
			.clk(clk),
			.rst_n(rst_n),
			.cmd_addr(m_icb_cmd_addr[k]),
			.cmd_read(m_icb_cmd_read[k]),
			.cmd_wdata(m_icb_cmd_wdata[k]),
			.cmd_wmask(m_icb_cmd_wmask[k]),
			.cmd_valid(m_icb_cmd_valid[k]),
			.cmd_ready(m_icb_cmd_ready[k]),
			.rsp_rdata(m_icb_rsp_rdata[k]),
			.rsp_err(m_icb_rsp_err[k]),
			.rsp_valid(m_icb_rsp_valid[k]),
			.rsp_ready(m_icb_rsp_ready[k])
		);
	end

endmodule

// ==== verif/tb_icb_tasks.svh ====
// icb driver tasks and reference model

`ifndef TB_ICB_TASKS_SVH
`define TB_ICB_TASKS_SVH

logic [7:0] ref_bytes [icb_pkg::SLV_NUM][MEM_BYTES]; // byte image of each slave

function automatic logic [icb_pkg::ICB_DW-1:0] model_word(input int k, input int off);
	logic [icb_pkg::ICB_DW-1:0] w;
	for (int b = 0; b < icb_pkg::ICB_MW; b++)
		w[b*8 +: 8] = ref_bytes[k][off + b];
	return w;
endfunction

task automatic model_write(input int k, input int off, input logic [icb_pkg::ICB_DW-1:0] data,
		input logic [icb_pkg::ICB_MW-1:0] mask);
	for (int b = 0; b < icb_pkg::ICB_MW; b++) begin
		if (mask[b])
			ref_bytes[k][off + b] = data[b*8 +: 8];
	end
endtask

task automatic compare_data(input string name, input logic [icb_pkg::ICB_DW-1:0] got,
		input logic [icb_pkg::ICB_DW-1:0] exp);
	if (got !== exp) begin
		$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
		err_cnt++;
	end
endtask

task automatic compare_err(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
		err_cnt++;
	end
endtask

// called 2 ns after a rising edge and samples ready on the falling edge
task automatic issue_cmd(input logic [icb_pkg::ICB_AW-1:0] addr, input logic read,
		input logic [icb_pkg::ICB_DW-1:0] wdata, input logic [icb_pkg::ICB_MW-1:0] wmask);
	int waited;
	waited = 0;
	cmd_addr = addr;
	cmd_read = read;
	cmd_wdata = wdata;
	cmd_wmask = wmask;
	cmd_valid = 1'b1;
	@(negedge clk);
	while (!cmd_ready && waited < WAIT_LIMIT) begin
		waited++;
		@(negedge clk);
	end
	if (!cmd_ready) begin
		$display("command to 0x%h was never accepted", addr);
		err_cnt++;
	end
	@(posedge clk);
	#2;
	cmd_valid = 1'b0;
endtask

task automatic collect_rsp(output logic [icb_pkg::ICB_DW-1:0] data, output logic err);
	int waited;
	waited = 0;
	rsp_ready = 1'b1;
	@(negedge clk);
	while (!rsp_valid && waited < WAIT_LIMIT) begin
		waited++;
		@(negedge clk);
	end
	if (!rsp_valid) begin
		$display("no response arrived within %0d cycles", WAIT_LIMIT);
		err_cnt++;
	end
	data = rsp_rdata; // stable until the transfer edge
	err = rsp_err;
	@(posedge clk);
	#2;
	rsp_ready = 1'b0;
	rsp_drained++;
endtask

// one command and its response checked against the model
task automatic bus_access(input int k, input int off, input logic read,
		input logic [icb_pkg::ICB_DW-1:0] wdata, input logic [icb_pkg::ICB_MW-1:0] wmask);
	logic [icb_pkg::ICB_DW-1:0] data;
	logic err;
	logic exp_err;
	exp_err = (off >= MEM_BYTES);
	issue_cmd(icb_pkg::SLV_BASE[k] + off, read, wdata, wmask);
	collect_rsp(data, err);
	compare_err("s_icb_rsp_err", err, exp_err);
	if (read)
		compare_data("s_icb_rsp_rdata", data, exp_err ? '0 : model_word(k, off));
	else if (!exp_err)
		model_write(k, off, wdata, wmask);
endtask

`endif

// ==== verif/tb_icb_subsys.sv ====
// icb subsystem testbench

`timescale 1ns/100ps

module tb_icb_subsys;

	localparam int NUM_TESTS = 5;
	localparam int WAIT_LIMIT = 100; // cycles before a handshake counts as hung
	localparam int MEM_BYTES = icb_pkg::SLV_MEM_WORDS * 4;

	logic clk;
	logic rst_n;
	logic [icb_pkg::ICB_AW-1:0] cmd_addr;
	logic cmd_read;
	logic [icb_pkg::ICB_DW-1:0] cmd_wdata;
	logic [icb_pkg::ICB_MW-1:0] cmd_wmask;
	logic cmd_valid;
	logic cmd_ready;
	logic [icb_pkg::ICB_DW-1:0] rsp_rdata;
	logic rsp_err;
	logic rsp_valid;
	logic rsp_ready;
	int err_cnt = 0;
	int tests_failed = 0;
	int rsp_drained = 0;
	int unsigned seed;

	icb_subsys_top i_icb_subsys_top (
		.clk(clk),
		.rst_n(rst_n),
		.s_icb_cmd_addr(cmd_addr),
		.s_icb_cmd_read(cmd_read),
		.s_icb_cmd_wdata(cmd_wdata),
		.s_icb_cmd_wmask(cmd_wmask),
		.s_icb_cmd_valid(cmd_valid),
		.s_icb_cmd_ready(cmd_ready),
		.s_icb_rsp_rdata(rsp_rdata),
		.s_icb_rsp_err(rsp_err),
		.s_icb_rsp_valid(rsp_valid),
		.s_icb_rsp_ready(rsp_ready)
	);

	`include "tb_icb_tasks.svh"

	always #20 clk = ~clk;

	initial begin
		#(NUM_TESTS * 2000 * 40);
		$display("watchdog expired before the test sequence finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

	task automatic finish_test(input string name, input int start);
		if (err_cnt == start) begin
			$display("test %s done, no errors", name);
		end else begin
			tests_failed++;
			$display("test %s done, %0d errors", name, err_cnt - start);
		end
	endtask

	task automatic route_windows();
		int start;
		int off;
		logic [icb_pkg::ICB_DW-1:0] data;
		start = err_cnt;
		for (int k = 0; k < icb_pkg::SLV_NUM; k++) begin
			off = ($urandom % icb_pkg::SLV_MEM_WORDS) * 4;
			data = $urandom;
			bus_access(k, off, 1'b0, data, '1);
			bus_access(k, off, 1'b1, '0, '0);
		end
		finish_test("window routing", start);
	endtask

	task automatic isolate_slaves();
		int start;
		start = err_cnt;
		for (int k = 0; k < icb_pkg::SLV_NUM; k++)
			bus_access(k, 0, 1'b0, 32'h1111_1111 * (k + 1), '1);
		for (int k = 0; k < icb_pkg::SLV_NUM; k++)
			bus_access(k, 0, 1'b1, '0, '0);
		finish_test("slave isolation", start);
	endtask

	task automatic merge_byte_masks();
		int start;
		start = err_cnt;
		bus_access(2, 8, 1'b0, $urandom, 4'b1111);
		bus_access(2, 8, 1'b0, $urandom, 4'b0101); // bytes 0 and 2 only
		bus_access(2, 8, 1'b1, '0, '0);
		bus_access(2, 8, 1'b0, $urandom, 4'b1000);
		bus_access(2, 8, 1'b1, '0, '0);
		finish_test("byte masks", start);
	endtask

	task automatic reject_out_of_range();
		int start;
		start = err_cnt;
		bus_access(3, MEM_BYTES, 1'b1, '0, '0);
		bus_access(3, 16'h1004, 1'b1, '0, '0);
		bus_access(3, MEM_BYTES, 1'b0, 32'hdead_beef, '1); // would alias word 0
		bus_access(3, 0, 1'b1, '0, '0);
		finish_test("out of range error", start);
	endtask

	task automatic order_responses();
		int order [5] = '{4, 0, 3, 1, 2};
		int offs [5] = '{0, 0, 0, 0, 8};
		int start;
		logic [icb_pkg::ICB_DW-1:0] data;
		logic err;
		start = err_cnt;
		rsp_drained = 0;
		for (int i = 0; i < 4; i++)
			issue_cmd(icb_pkg::SLV_BASE[order[i]] + offs[i], 1'b1, '0, '0);
		fork
			begin
				issue_cmd(icb_pkg::SLV_BASE[order[4]] + offs[4], 1'b1, '0, '0);
				if (rsp_drained == 0) begin
					$display("fifth command accepted while four were outstanding");
					err_cnt++;
				end
			end
			begin
				repeat (8) @(negedge clk); // all four held behind rsp_ready low
				@(posedge clk);
				#2;
				for (int i = 0; i < 5; i++) begin
					collect_rsp(data, err);
					compare_err("s_icb_rsp_err", err, 1'b0);
					compare_data("s_icb_rsp_rdata", data, model_word(order[i], offs[i]));
				end
			end
		join
		finish_test("ordering and back-pressure", start);
	endtask

	initial begin
		seed = 32'hf8b5_f54a;
		void'($urandom(seed));
		clk = 1'b0;
		rst_n = 1'b0;
		cmd_addr = '0;
		cmd_read = 1'b0;
		cmd_wdata = '0;
		cmd_wmask = '0;
		cmd_valid = 1'b0;
		rsp_ready = 1'b0;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		route_windows();
		isolate_slaves();
		merge_byte_masks();
		reject_out_of_range();
		order_responses();
		$display("tests run %0d, tests failed %0d, errors %0d", NUM_TESTS, tests_failed, err_cnt);
		if (err_cnt == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+verif
hdl/icb_pkg.sv
hdl/fifo_based_on_regs.sv
hdl/icb_mem_slave.sv
hdl/icb_1s_to_5m.sv
hdl/icb_subsys_top.sv
verif/tb_icb_subsys.sv
